/* all.f */
+incdir+common
common/dout_pkg.sv
dout_ctrl/dout_pwm.sv
dout_ctrl/dout_ctrl.sv
design/dout_cfg_detect.sv
design/dout_status_regs.sv
design/dout_top.sv
sim/dout_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = dout_tb
FLIST     = all.f
MDIR      = obj_dir
BIN       = $(MDIR)/V$(TOP)

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard common/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(BIN): $(FLIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FLIST)

# pass or fail comes from the simulator output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(MDIR)

/* sim/dout_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dout_macros.svh"

module dout_tb
    import dout_pkg::*;
();

    localparam int NUM_ROWS  = 8;
    localparam int DET_LIMIT = 20;                 // edges allowed for board detection
    localparam logic [15:0] STATUS_ADDR  = {`ADDR_MAIN, 8'h00, `REG_STATUS};
    localparam logic [15:0] DIGIOUT_ADDR = {`ADDR_MAIN, 8'h00, `REG_DIGIOUT};

    // one stimulus row
    typedef struct packed {
        logic        board;       // 0 for pull-downs on the newer board or 1 for the older
        logic [2:0]  ch;          // channel 1..4
        logic [15:0] hi_time;
        logic [15:0] lo_time;
        logic        lvl;         // level written after the control word
        logic        rnd;         // times drawn from the LCG
        logic [15:0] cycles;      // samples to observe
        logic [7:0]  restart;     // sample index of a control rewrite or 0 for none
        logic [15:0] exp_hi;
        logic [15:0] exp_lo;
    } row_t;

    logic                       sysclk;
    logic                       reset;
    reg_wr_t                    reg_wr;
    logic [15:0]                reg_raddr;
    logic [1:0]                 dir_in;
    logic [31:0]                reg_rdata;
    logic [`DOUT_NUM_CH-1:0]    dout_pins;
    logic                       dir_drive;
    logic                       board_pull;    // level the board resistors pull to
    logic [31:0]                lcg_state;
    row_t                       rows [NUM_ROWS];
    int                         errors;
    int                         tests;
    int                         failed;

    always #50 sysclk = ~sysclk;               // 100 ns period

    // resistors pull the lines and a driven line reads high
    always @(negedge sysclk) begin
        dir_in = dir_drive ? 2'b11 : {2{board_pull}};
    end

    dout_top UUT (
        .sysclk    (sysclk),
        .reset     (reset),
        .reg_wr    (reg_wr),
        .reg_raddr (reg_raddr),
        .dir_in    (dir_in),
        .reg_rdata (reg_rdata),
        .dout_pins (dout_pins),
        .dir_drive (dir_drive)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] ctrl_addr(input logic [3:0] ch);
        return {`ADDR_MAIN, 4'h0, ch, `OFF_DOUT_CTRL};
    endfunction

    // mask bit plus level bit for one channel
    function automatic logic [31:0] lvl_word(input logic [2:0] ch, input logic lvl);
        logic [3:0] m;
        m = 4'b0001 << (ch - 3'd1);
        return {20'h0, m, 4'h0, lvl ? m : 4'h0};
    endfunction

    task automatic draw_time(output logic [15:0] t);
        lcg_state = lcg_next(lcg_state);
        t = (lcg_state[23:8] % 16'd20) + 16'd1;  // range 1..20
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got == exp) else begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int first_err);
        tests++;
        if (errors > first_err) begin
            failed++;
            $display("test %0d %s: FAILED, %0d errors", tests, name, errors - first_err);
        end else begin
            $display("test %0d %s: ok", tests, name);
        end
    endtask

    task automatic load_table();
        // board ch hi lo lvl rnd cycles restart exp_hi exp_lo
        rows[0] = '{1'b0, 3'd1, 16'd5,  16'd0, 1'b1, 1'b0, 16'd30,  8'd0, 16'd6,   16'd24};
        rows[1] = '{1'b1, 3'd2, 16'd0,  16'd7, 1'b0, 1'b0, 16'd30,  8'd0, 16'd22,  16'd8};
        rows[2] = '{1'b1, 3'd3, 16'd3,  16'd4, 1'b1, 1'b0, 16'd27,  8'd0, 16'd12,  16'd15};
        rows[3] = '{1'b0, 3'd4, 16'd0,  16'd0, 1'b1, 1'b1, 16'd0,   8'd0, 16'd0,   16'd0};
        rows[4] = '{1'b1, 3'd1, 16'd0,  16'd0, 1'b0, 1'b1, 16'd0,   8'd0, 16'd0,   16'd0};
        rows[5] = '{1'b0, 3'd2, 16'd0,  16'd0, 1'b1, 1'b0, 16'd200, 8'd0, 16'd200, 16'd0};
        rows[6] = '{1'b1, 3'd3, 16'd12, 16'd0, 1'b1, 1'b0, 16'd40,  8'd4, 16'd18,  16'd22};
        rows[7] = '{1'b0, 3'd4, 16'd1,  16'd1, 1'b0, 1'b0, 16'd16,  8'd0, 16'd8,   16'd8};
    endtask

    task automatic apply_reset(input logic board);
        @(negedge sysclk);
        reset      = 1'b0;
        board_pull = board;
        reg_wr     = '0;
        reg_raddr  = STATUS_ADDR;              // status stays addressed while idle
        repeat (10) @(negedge sysclk);
        reset = 1'b1;
    endtask

    // cfg_valid must rise on the third edge after reset release
    task automatic wait_detect(input logic board);
        int   k;
        logic seen;
        seen = 1'b0;
        k    = 0;
        while (!seen && k < DET_LIMIT) begin
            @(negedge sysclk);
            k++;                                // edges seen so far
            #1;
            seen = reg_rdata[31];
        end
        assert (seen) else begin
            $display("board detection timed out, cfg_valid never rose");
            errors++;
        end
        check_val("edges to cfg_valid", k, 3);
        check_val("cfg_bidir", reg_rdata[30], !board);
        check_val("dir_drive", dir_drive, !board);
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        @(negedge sysclk);
        reg_wr.wen   = 1'b1;
        reg_wr.waddr = addr;
        reg_wr.wdata = data;
        @(negedge sysclk);
        reg_wr.wen = 1'b0;                     // single cycle strobe
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [31:0] data);
        @(negedge sysclk);
        reg_raddr = addr;
        #1;
        data = reg_rdata;                      // combinational read path
    endtask

    task automatic check_levels(input logic [3:0] want, input logic bidir);
        logic [31:0] rd;
        logic [3:0]  pins_exp;
        pins_exp = want ^ {4{bidir}};          // newer board shows every level inverted
        read_reg(STATUS_ADDR, rd);
        check_val("status levels", rd[3:0], want);
        check_val("dout_pins", dout_pins, pins_exp);
    endtask

    // samples one channel each cycle to count levels and check every finished run
    task automatic observe(input row_t r, input logic bidir,
                           output int n_hi, output int n_lo);
        int          i;
        int          run;
        logic        lvl;
        logic        prev;
        logic [15:0] want;
        n_hi = 0;
        n_lo = 0;
        run  = 0;
        prev = r.lvl;
        for (i = 0; i < int'(r.cycles); i++) begin
            if (i > 0) begin
                @(negedge sysclk);
            end
            reg_wr.wen   = (r.restart != 8'd0) && (i == int'(r.restart));
            reg_wr.waddr = ctrl_addr({1'b0, r.ch});
            reg_wr.wdata = {r.hi_time, r.lo_time};   // rewrite restarts the timer
            #1;
            lvl = reg_rdata[r.ch - 3'd1];
            if (i == 0) begin
                check_val("first level", lvl, r.lvl);
            end
            check_val("dout_pins", dout_pins[r.ch - 3'd1], lvl ^ bidir);
            if (lvl) begin
                n_hi++;
            end else begin
                n_lo++;
            end
            if (i == 0 || lvl == prev) begin
                run++;
            end else begin
                if (r.restart == 8'd0) begin
                    want = prev ? r.hi_time : r.lo_time;
                    if (prev) begin
                        check_val("high run", run, want + 16'd1);
                    end else begin
                        check_val("low run", run, want + 16'd1);
                    end
                end
                run = 1;
            end
            prev = lvl;
        end
        reg_wr.wen = 1'b0;
    endtask

    task automatic masked_levels(input logic board);
        int k;
        apply_reset(board);
        wait_detect(board);
        write_reg(DIGIOUT_ADDR, 32'h0000_0F05);   // all masks with levels 0101
        check_levels(4'b0101, !board);
        write_reg(DIGIOUT_ADDR, 32'h0000_0600);   // clear ch2 and ch3 only
        check_levels(4'b0001, !board);
        write_reg(DIGIOUT_ADDR, 32'h0000_0A0E);   // ch3 data bit has no mask
        for (k = 0; k < 200; k++) begin
            check_levels(4'b1011, !board);        // zero times hold the levels
        end
    endtask

    task automatic readback_check();
        logic [31:0] words [`DOUT_NUM_CH];
        logic [31:0] rd;
        int          c;
        apply_reset(1'b1);
        wait_detect(1'b1);
        for (c = 0; c < `DOUT_NUM_CH; c++) begin
            lcg_state = lcg_next(lcg_state);
            words[c]  = lcg_state;
            write_reg(ctrl_addr(4'(c + 1)), words[c]);
        end
        for (c = 0; c < `DOUT_NUM_CH; c++) begin
            read_reg(ctrl_addr(4'(c + 1)), rd);
            check_val("ctrl word", rd, words[c]);
        end
        for (c = 0; c < 16; c++) begin
            if (c == 0 || c > `DOUT_NUM_CH) begin
                read_reg(ctrl_addr(4'(c)), rd);
                check_val("bad channel read", rd, 32'h0);
            end
        end
        for (c = 1; c < 16; c++) begin          // offset 0 is status
            if (c != int'(`OFF_DOUT_CTRL)) begin
                read_reg({`ADDR_MAIN, 4'h0, 4'h1, 4'(c)}, rd);
                check_val("unmapped offset read", rd, 32'h0);
            end
        end
        read_reg({4'h1, 4'h0, 4'h1, `OFF_DOUT_CTRL}, rd);
        check_val("other block read", rd, 32'h0);
    endtask

    initial begin
        row_t        r;
        int          t;
        int          n_hi;
        int          n_lo;
        int          first_err;
        logic [31:0] rd;
        sysclk     = 1'b0;
        reset      = 1'b0;
        reg_wr     = '0;
        reg_raddr  = STATUS_ADDR;
        dir_in     = 2'b11;
        board_pull = 1'b1;
        lcg_state  = 32'h9550_b123;
        errors     = 0;
        tests      = 0;
        failed     = 0;
        load_table();
        for (t = 0; t < NUM_ROWS; t++) begin
            r         = rows[t];
            first_err = errors;
            if (r.rnd) begin                   // three full PWM periods
                draw_time(r.hi_time);
                draw_time(r.lo_time);
                r.cycles = 16'd3 * (r.hi_time + r.lo_time + 16'd2);
                r.exp_hi = 16'd3 * (r.hi_time + 16'd1);
                r.exp_lo = 16'd3 * (r.lo_time + 16'd1);
            end
            apply_reset(r.board);
            wait_detect(r.board);
            write_reg(ctrl_addr({1'b0, r.ch}), {r.hi_time, r.lo_time});
            read_reg(ctrl_addr({1'b0, r.ch}), rd);
            check_val("ctrl readback", rd, {r.hi_time, r.lo_time});
            read_reg(STATUS_ADDR, rd);
            write_reg(DIGIOUT_ADDR, lvl_word(r.ch, r.lvl));
            observe(r, !r.board, n_hi, n_lo);
            check_val("high cycles", n_hi, r.exp_hi);
            check_val("low cycles", n_lo, r.exp_lo);
            report_test($sformatf("row %0d ch%0d H=%0d L=%0d", t, r.ch, r.hi_time,
                                  r.lo_time), first_err);
        end
        first_err = errors;
        masked_levels(1'b0);
        report_test("masked levels, newer board", first_err);
        first_err = errors;
        masked_levels(1'b1);
        report_test("masked levels, older board", first_err);
        first_err = errors;
        readback_check();
        report_test("control readback and unmapped reads", first_err);
        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/dout_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dout_macros.svh"

module dout_top
    import dout_pkg::*;
(
    input  wire                         sysclk,
    input  wire                         reset,        // sync, active low
    input  wire reg_wr_t                reg_wr,       // host write bundle
    input  wire  [15:0]                 reg_raddr,
    input  wire  [1:0]                  dir_in,       // sensed direction lines
    output logic [31:0]                 reg_rdata,
    output logic [`DOUT_NUM_CH-1:0]     dout_pins,
    output logic                        dir_drive
);

    logic [31:0]                ctrl_rdata;
    logic [`DOUT_NUM_CH-1:0]    levels;
    logic                       cfg_valid;
    logic                       cfg_bidir;

    dout_ctrl u_ctrl (
        .sysclk     (sysclk),
        .reset      (reset),
        .reg_wr     (reg_wr),
        .ctrl_raddr (reg_raddr[7:4]),    // channel field only
        .cfg_bidir  (cfg_bidir),
        .ctrl_rdata (ctrl_rdata),
        .levels     (levels),
        .dout_pins  (dout_pins)
    );

    dout_cfg_detect u_detect (
        .sysclk     (sysclk),
        .reset      (reset),
        .dir_in     (dir_in),
        .dir_drive  (dir_drive),
        .cfg_valid  (cfg_valid),
        .cfg_bidir  (cfg_bidir)
    );

    dout_status_regs u_status (
        .reg_raddr  (reg_raddr),
        .ctrl_rdata (ctrl_rdata),
        .levels     (levels),
        .cfg_valid  (cfg_valid),
        .cfg_bidir  (cfg_bidir),
        .reg_rdata  (reg_rdata)
    );

endmodule

`default_nettype wire

/* design/dout_status_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dout_macros.svh"

module dout_status_regs
    import dout_pkg::*;
(
    input  wire  [15:0]                 reg_raddr,    // host read address
    input  wire  [31:0]                 ctrl_rdata,   // control word picked by dout_ctrl
    input  wire  [`DOUT_NUM_CH-1:0]     levels,       // logical channel levels
    input  wire                         cfg_valid,
    input  wire                         cfg_bidir,
    output logic [31:0]                 reg_rdata     // same-cycle read data
);

    dout_status_t   status;
    logic           rd_main;          // read aimed at the main block

    always_comb begin
        status           = '0;
        status.cfg_valid = cfg_valid;
        status.cfg_bidir = cfg_bidir;
        status.levels    = levels;    // before any pin inversion
    end

    assign rd_main = (reg_raddr[15:12] == `ADDR_MAIN);

    // purely combinational, data follows the address in the same cycle
    always_comb begin
        reg_rdata = '0;                                  // unmapped reads give zero
        if (rd_main) begin
            if (reg_raddr[3:0] == `OFF_DOUT_CTRL) begin
                reg_rdata = ctrl_rdata;                  // bad channel already zero
            end else if (reg_raddr[3:0] == `REG_STATUS && reg_raddr[7:4] == 4'd0) begin
                reg_rdata = status;
            end
        end
    end

endmodule

`default_nettype wire

/* design/dout_cfg_detect.sv */
`timescale 1ns/1ps
`default_nettype none

module dout_cfg_detect
    import dout_pkg::*;
(
    input  wire         sysclk,
    input  wire         reset,       // sync, active low
    input  wire  [1:0]  dir_in,      // sensed direction lines
    output logic        dir_drive,   // drive both direction lines high
    output logic        cfg_valid,   // board revision decided
    output logic        cfg_bidir    // newer board found
);

    logic [1:0]   dir_meta;          // first synchronizer stage
    logic [1:0]   dir_sync;          // second stage, safe to use
    logic [1:0]   sync_vld;          // tracks when dir_sync holds real samples
    cfg_state_t   state;
    cfg_state_t   state_nxt;

    // plain two-flop synchronizer on each line
    always_ff @(posedge sysclk) begin
        dir_meta <= dir_in;
        dir_sync <= dir_meta;
    end

    // dir_sync is only trusted two edges after reset release
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            sync_vld <= 2'b00;
        end else begin
            sync_vld <= {sync_vld[0], 1'b1};
        end
    end

    always_comb begin
        state_nxt = state;
        if (state == CFG_SENSE && sync_vld[1]) begin
            if (dir_sync == 2'b00) begin
                state_nxt = CFG_BIDIR;               // pull-downs, newer board
            end else if (dir_sync == 2'b11) begin
                state_nxt = CFG_LEGACY;              // floating high, older board
            end
            // mixed reading, keep sampling
        end
    end

    // outputs taken from the next state so they switch on the deciding edge
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            state     <= CFG_SENSE;
            dir_drive <= 1'b0;                       // lines released
            cfg_valid <= 1'b0;
            cfg_bidir <= 1'b0;
        end else begin
            state     <= state_nxt;
            dir_drive <= (state_nxt == CFG_BIDIR);
            cfg_valid <= (state_nxt != CFG_SENSE);
            cfg_bidir <= (state_nxt == CFG_BIDIR);
        end
    end

endmodule

`default_nettype wire

/* dout_ctrl/dout_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dout_macros.svh"

module dout_ctrl
    import dout_pkg::*;
(
    input  wire                         sysclk,
    input  wire                         reset,        // sync, active low
    input  wire reg_wr_t                reg_wr,       // host write bundle
    input  wire  [3:0]                  ctrl_raddr,   // channel field of the read address
    input  wire                         cfg_bidir,    // newer board, pins inverted
    output logic [31:0]                 ctrl_rdata,   // addressed control word
    output logic [`DOUT_NUM_CH-1:0]     levels,       // logical levels
    output logic [`DOUT_NUM_CH-1:0]     dout_pins     // levels as driven on the board
);

    logic                       wr_main;      // write aimed at the main block
    logic                       lvl_hit;      // write to the output level register
    logic                       ctrl_hit;     // write to some control word offset
    logic [`DOUT_NUM_CH-1:0]    lvl_wr;       // per-channel level strobe
    logic [`DOUT_NUM_CH-1:0]    ctrl_wr;      // per-channel control strobe
    logic [`DOUT_NUM_CH-1:0]    lvl_new;      // per-channel new level
    logic [31:0]                ctrl_rd [`DOUT_NUM_CH];

    assign wr_main = reg_wr.wen && (reg_wr.waddr[15:12] == `ADDR_MAIN);

    // level register only answers with the channel field at zero
    assign lvl_hit = wr_main
                     && (reg_wr.waddr[7:4] == 4'd0)
                     && (reg_wr.waddr[3:0] == `REG_DIGIOUT);

    assign ctrl_hit = wr_main && (reg_wr.waddr[3:0] == `OFF_DOUT_CTRL);

    genvar g;
    generate
        for (g = 0; g < `DOUT_NUM_CH; g++) begin : g_ch
            // mask bits sit at wdata[11:8], levels at wdata[3:0]
            assign lvl_wr[g]  = lvl_hit && reg_wr.wdata[8+g];
            assign lvl_new[g] = reg_wr.wdata[g];

            // channels are numbered from 1 in the address
            assign ctrl_wr[g] = ctrl_hit && (reg_wr.waddr[7:4] == 4'(g + 1));

            dout_pwm u_pwm (
                .sysclk    (sysclk),
                .reset     (reset),
                .ctrl_wr   (ctrl_wr[g]),
                .ctrl_word (reg_wr.wdata),      // control data passes straight through
                .lvl_wr    (lvl_wr[g]),
                .lvl_new   (lvl_new[g]),
                .ctrl_rd   (ctrl_rd[g]),
                .level     (levels[g])
            );
        end
    endgenerate

    // control word read mux, channel 0 and 5..15 return zero
    always_comb begin
        ctrl_rdata = '0;
        for (int i = 0; i < `DOUT_NUM_CH; i++) begin
            if (ctrl_raddr == 4'(i + 1)) begin
                ctrl_rdata = ctrl_rd[i];
            end
        end
    end

    // older boards inverted in the MOSFET stage, newer ones match that here
    assign dout_pins = cfg_bidir ? ~levels : levels;

endmodule

`default_nettype wire

/* dout_ctrl/dout_pwm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dout_macros.svh"

module dout_pwm (
    input  wire                          sysclk,
    input  wire                          reset,       // sync, active low
    input  wire                          ctrl_wr,     // store new control word
    input  wire  [2*`DOUT_TIME_W-1:0]    ctrl_word,
    input  wire                          lvl_wr,      // force level to lvl_new
    input  wire                          lvl_new,
    output logic [2*`DOUT_TIME_W-1:0]    ctrl_rd,     // control word readback
    output logic                         level        // logical output level
);

    logic [2*`DOUT_TIME_W-1:0] hilo_time;   // high time in upper half, low time in lower
    logic [`DOUT_TIME_W-1:0]   cur_time;    // running count for the current level
    logic [`DOUT_TIME_W-1:0]   want_time;   // time allowed for the current level

    // pick the time that belongs to the level we are in
    always_comb begin
        if (level) begin
            want_time = hilo_time[2*`DOUT_TIME_W-1:`DOUT_TIME_W];
        end else begin
            want_time = hilo_time[`DOUT_TIME_W-1:0];
        end
    end

    assign ctrl_rd = hilo_time;

    // a level lasts want_time+1 clocks, since the count runs 0..want_time
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            level     <= 1'b0;
            hilo_time <= '0;
            cur_time  <= '0;
        end else if (lvl_wr) begin               // level write wins over control write
            level    <= lvl_new;
            cur_time <= '0;                      // restart timer
        end else if (ctrl_wr) begin
            hilo_time <= ctrl_word;
            cur_time  <= '0;                     // new times start from zero
        end else if (want_time != '0) begin      // zero time means hold forever
            if (cur_time == want_time) begin
                level    <= ~level;              // time used up, flip
                cur_time <= '0;
            end else begin
                cur_time <= cur_time + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* common/dout_pkg.sv */
`default_nettype none

`include "dout_macros.svh"

package dout_pkg;

    // one host register write, wen is a single cycle strobe
    typedef struct packed {
        logic        wen;
        logic [15:0] waddr;       // block / channel / offset fields
        logic [31:0] wdata;
    } reg_wr_t;

    // status word as seen by the host
    typedef struct packed {
        logic                        cfg_valid;    // bit 31, board revision known
        logic                        cfg_bidir;    // bit 30, newer board with transceivers
        logic [29-`DOUT_NUM_CH:0]    zero_fill;
        logic [`DOUT_NUM_CH-1:0]     levels;       // logical levels before pin inversion
    } dout_status_t;

    // board revision detector
    typedef enum logic [1:0] {
        CFG_SENSE  = 2'd0,        // lines released, sampling
        CFG_BIDIR  = 2'd1,        // pull-downs seen, newer board
        CFG_LEGACY = 2'd2         // lines read high, older board
    } cfg_state_t;

endpackage

`default_nettype wire

/* common/dout_macros.svh */
`ifndef DOUT_MACROS_SVH
`define DOUT_MACROS_SVH

// channel count and timer width
`define DOUT_NUM_CH     4
`define DOUT_TIME_W     16        // one high or low time, in clocks

// address map
// waddr/raddr[15:12] block, [7:4] channel, [3:0] offset
`define ADDR_MAIN       4'h0      // block field of the main register set
`define REG_STATUS      4'h0      // status word, read only
`define REG_DIGIOUT     4'h6      // output levels, wdata[11:8] masks, wdata[3:0] levels
`define OFF_DOUT_CTRL   4'h8      // per-channel control word, channel 1..4

`endif
